/* build.f */
hdl/dga_pkg.sv
hdl/panel_if.sv
hdl/panel_fifo.sv
hdl/power_seq.sv
hdl/comm_decode.sv
hdl/decode_dga.sv
verif/decode_dga_chk.sv
verif/tb_decode_dga.sv

/* hdl/comm_decode.sv */
// ********************
// registered command decoder
// status nibble routing onto the bus
// panel FIFO write control
// ********************

`timescale 1ns/1ps

module comm_decode
  import dga_pkg::*;
(
  input  logic           clk,
  input  logic           reset,
  input  logic           clear,
  input  cmd_e           cmd,
  input  logic [7:0]     idb_in,
  input  status_t        status,
  panel_if.writer        pwr,
  output logic           clr_fail,
  output logic           stop_set,
  output logic           start_set,
  output logic           epan_n,
  output logic [3:0]     idb_out
);

  cmd_e       cmd_q;
  logic [7:0] idb_q;
  logic       ld_pan;
  logic       ld_stat;
  logic [3:0] stat_nib;
  logic [7:0] wr_byte;

  // ********************
  // input registers
  // ********************

  // command register cleared to nop in reset
  always_ff @(posedge clk) begin
    if (reset) begin
      cmd_q <= cmd_nop;
    end else begin
      cmd_q <= cmd;
    end
  end

  // bus byte captured with the command
  always_ff @(posedge clk) begin
    idb_q <= idb_in;
  end

  // ********************
  // decode
  // ********************

  // one single-cycle strobe per registered command
  always_comb begin
    ld_pan    = 1'b0;
    ld_stat   = 1'b0;
    clr_fail  = 1'b0;
    stop_set  = 1'b0;
    start_set = 1'b0;
    case (cmd_q)
      cmd_ldpan:   ld_pan    = 1'b1;
      cmd_ldstat:  ld_stat   = 1'b1;
      cmd_clrfail: clr_fail  = 1'b1;
      cmd_stop:    stop_set  = 1'b1;
      cmd_start:   start_set = 1'b1;
      // nop and unused codes leave every strobe low
      default: ;
    endcase
  end

  // ********************
  // status nibble
  // ********************

  // bit 3 always zero when the status goes out
  assign stat_nib = {1'b0, status};

  // status load takes the low nibble from the sequencer
  // plain panel load takes the whole bus byte
  assign wr_byte = ld_stat ? {idb_q[7:4], stat_nib} : idb_q;

  // ********************
  // FIFO write
  // ********************

  // nothing queued during clear
  // full FIFO drops the byte here
  assign pwr.wr_en   = (ld_pan || ld_stat) && !clear && pwr.full_n;
  assign pwr.wr_data = wr_byte;

  // ********************
  // bus output routing
  // ********************

  // epan_n low only in the cycle after a status load command
  assign epan_n = !ld_stat;

  // status on the bus while enabled
  // otherwise the low nibble of the bus loops straight through
  assign idb_out = ld_stat ? stat_nib : idb_in[3:0];

endmodule

/* hdl/decode_dga.sv */
// ********************
// panel and decode top level
// decoder, power sequencer and panel FIFO
// ********************

`timescale 1ns/1ps

module decode_dga
  import dga_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  // command and internal data bus
  input  logic [4:0] cmd,
  input  logic [7:0] idb_in,
  input  logic       power_sense,
  // processor read handshake
  input  logic       rd_req,
  output logic       rd_ack,
  output logic [7:0] a,
  // status nibble back onto the bus
  output logic [3:0] idb_out,
  output logic       epan_n,
  // panel FIFO flags
  output logic       full_n,
  output logic       empty_n,
  // power and run state
  output logic       clear_n,
  output logic       pow_fail_n,
  output logic       stopped
);

  logic    clear;
  logic    clr_fail;
  logic    stop_set;
  logic    start_set;
  status_t status;

  // ********************
  // panel FIFO bundle
  // ********************

  panel_if pif (
    .clk   (clk),
    .reset (reset)
  );

  // processor side of the read port
  assign pif.rd_req = rd_req;
  assign rd_ack     = pif.rd_ack;
  assign a          = pif.rd_data;
  assign full_n     = pif.full_n;
  assign empty_n    = pif.empty_n;

  // ********************
  // sub blocks
  // ********************

  power_seq u_pow (
    .clk         (clk),
    .reset       (reset),
    .power_sense (power_sense),
    .clr_fail    (clr_fail),
    .stop_set    (stop_set),
    .start_set   (start_set),
    .clear       (clear),
    .pow_fail_n  (pow_fail_n),
    .status      (status)
  );

  comm_decode u_comm (
    .clk       (clk),
    .reset     (reset),
    .clear     (clear),
    .cmd       (cmd_e'(cmd)),
    .idb_in    (idb_in),
    .status    (status),
    .pwr       (pif.writer),
    .clr_fail  (clr_fail),
    .stop_set  (stop_set),
    .start_set (start_set),
    .epan_n    (epan_n),
    .idb_out   (idb_out)
  );

  panel_fifo u_fifo (
    .clk   (clk),
    .reset (reset),
    .clear (clear),
    .pif   (pif.store)
  );

  // pin level status
  assign clear_n = !clear;
  assign stopped = status.stopped;

endmodule

/* hdl/dga_pkg.sv */
// ********************
// shared constants for the panel and decode logic
// command codes and the status word type
// ********************

package dga_pkg;

  // ********************
  // panel FIFO sizing
  // ********************

  // entries in the panel byte queue
  localparam int fifo_depth = 13;
  // pointer and count width, holds 0 to 13
  localparam int ptr_w = 4;

  // ********************
  // clear sequencer
  // ********************

  // clear pulse length in clock cycles
  localparam int clear_cycles = 8;
  // counter width for the clear pulse
  localparam int clr_cnt_w = 4;

  // command codes on the 5-bit command bus
  // codes not listed act as no operation
  typedef enum logic [4:0] {
    cmd_nop     = 5'd0,
    cmd_ldpan   = 5'd1,
    cmd_ldstat  = 5'd2,
    cmd_clrfail = 5'd3,
    cmd_stop    = 5'd4,
    cmd_start   = 5'd5
  } cmd_e;

  // status nibble bits, msb first
  typedef struct packed {
    logic fail_latched;
    logic clearing;
    logic stopped;
  } status_t;

endpackage

/* hdl/panel_fifo.sv */
// ********************
// 13 entry panel byte FIFO
// enable style write port
// four-phase req/ack read port
// ********************

`timescale 1ns/1ps

module panel_fifo
  import dga_pkg::*;
(
  input logic    clk,
  input logic    reset,
  input logic    clear,
  panel_if.store pif
);

  typedef enum logic [1:0] {
    rd_idle,
    rd_acked,
    rd_wait_drop
  } rd_state_e;

  logic [7:0]       mem [fifo_depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w-1:0] count;
  logic [7:0]       head_q;
  rd_state_e        rd_state;
  logic             rd_ack;
  logic             do_wr;
  logic             do_pop;

  // circular pointer step, wraps at the last entry
  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
    next_ptr = (p == ptr_w'(fifo_depth - 1)) ? '0 : p + 1'b1;
  endfunction

  // writes dropped when full or during clear
  assign do_wr  = pif.wr_en && !clear && (count != ptr_w'(fifo_depth));
  // pop on the edge where ack rises
  assign do_pop = (rd_state == rd_idle) && pif.rd_req && (count != '0) && !clear;

  // ********************
  // storage
  // ********************

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= pif.wr_data;
    end
  end

  // head byte held for the whole ack phase
  always_ff @(posedge clk) begin
    if (do_pop) begin
      head_q <= mem[rd_ptr];
    end
  end

  // pointers and fill count
  always_ff @(posedge clk) begin
    if (reset || clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({do_wr, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // ********************
  // read handshake
  // ********************

  // wait_drop after a clear abort, so a held req is not acked twice
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_state <= rd_idle;
    end else begin
      case (rd_state)
        rd_idle: begin
          if (do_pop) begin
            rd_state <= rd_acked;
          end
        end
        rd_acked: begin
          if (clear) begin
            rd_state <= rd_wait_drop;
          end else if (!pif.rd_req) begin
            rd_state <= rd_idle;
          end
        end
        rd_wait_drop: begin
          if (!pif.rd_req) begin
            rd_state <= rd_idle;
          end
        end
        default: rd_state <= rd_idle;
      endcase
    end
  end

  assign rd_ack      = (rd_state == rd_acked);
  assign pif.rd_ack  = rd_ack;
  // bus is zero outside the ack phase
  assign pif.rd_data = rd_ack ? head_q : 8'h00;
  assign pif.full_n  = (count != ptr_w'(fifo_depth));
  assign pif.empty_n = (count != '0);

endmodule

/* hdl/panel_if.sv */
// ********************
// panel FIFO bundle
// write side, read handshake and flags
// ********************

`timescale 1ns/1ps

interface panel_if (
  input logic clk,
  input logic reset
);

  // write side, from the decoder
  logic       wr_en;
  logic [7:0] wr_data;
  // flags and read side, from the FIFO
  logic       full_n;
  logic       empty_n;
  logic       rd_req;
  logic       rd_ack;
  logic [7:0] rd_data;

  modport writer (input clk, input reset, output wr_en, output wr_data, input full_n);

  modport store (
    input  clk, input reset,
    input  wr_en, input wr_data, input rd_req,
    output full_n, output empty_n, output rd_ack, output rd_data
  );

  modport reader (input clk, input reset, output rd_req, input rd_ack, input rd_data);

endinterface

/* hdl/power_seq.sv */
// ********************
// power sense synchronizer
// clear pulse generator
// power fail and stop flags
// ********************

`timescale 1ns/1ps

module power_seq
  import dga_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  logic    power_sense,
  input  logic    clr_fail,
  input  logic    stop_set,
  input  logic    start_set,
  output logic    clear,
  output logic    pow_fail_n,
  output status_t status
);

  logic                 sense_meta;
  logic                 sense_sync;
  logic                 sense_dly;
  logic                 sense_rise;
  logic                 sense_fall;
  logic [clr_cnt_w-1:0] clr_cnt;
  logic                 fail_q;
  logic                 stop_q;

  // ********************
  // sense synchronizer
  // ********************

  // two flops for metastability, third for edge detect
  always_ff @(posedge clk) begin
    sense_meta <= power_sense;
    sense_sync <= sense_meta;
    sense_dly  <= sense_sync;
  end

  assign sense_rise = sense_sync && !sense_dly;
  assign sense_fall = !sense_sync && sense_dly;

  // ********************
  // clear pulse
  // ********************

  // loaded in reset and on power return
  // high for clear_cycles cycles after either
  always_ff @(posedge clk) begin
    if (reset) begin
      clr_cnt <= clr_cnt_w'(clear_cycles);
    end else if (sense_rise) begin
      clr_cnt <= clr_cnt_w'(clear_cycles);
    end else if (clr_cnt != '0) begin
      clr_cnt <= clr_cnt - 1'b1;
    end
  end

  assign clear = (clr_cnt != '0);

  // ********************
  // status flags
  // ********************

  // power loss wins over a clear request in the same cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      fail_q <= 1'b0;
    end else if (sense_fall) begin
      fail_q <= 1'b1;
    end else if (clr_fail) begin
      fail_q <= 1'b0;
    end
  end

  // stop and start strobes from the panel
  always_ff @(posedge clk) begin
    if (reset) begin
      stop_q <= 1'b0;
    end else if (stop_set) begin
      stop_q <= 1'b1;
    end else if (start_set) begin
      stop_q <= 1'b0;
    end
  end

  assign pow_fail_n          = !fail_q;
  assign status.fail_latched = fail_q;
  assign status.clearing     = clear;
  assign status.stopped      = stop_q;

endmodule

/* run.sh */
#!/bin/sh
# compile and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_decode_dga -f build.f -o tb_sim

status=0
out=$(./obj_dir/tb_sim 2>&1) || status=$?
echo "$out"
[ "$status" -eq 0 ]

# pass only when the pass line appears
echo "$out" | grep -qx "Simulation passed"

/* verif/decode_dga_chk.sv */
// ********************
// bound checks on the panel FIFO
// read handshake, flags, held read data
// ********************

`timescale 1ns/1ps

module decode_dga_chk (
  input logic       clk,
  input logic       reset,
  input logic       rd_req,
  input logic       rd_ack,
  input logic       full_n,
  input logic       empty_n,
  input logic [7:0] rd_data
);

  // ack only answers a request sampled on the edge before
  ack_needs_req: assert property (@(posedge clk) disable iff (reset)
    $rose(rd_ack) |-> $past(rd_req))
    else $error("rd_ack rose without rd_req");

  // at most one write per edge, so an empty FIFO is never full next cycle
  no_empty_to_full: assert property (@(posedge clk) disable iff (reset)
    !empty_n |=> full_n)
    else $error("full_n fell straight after empty_n was low");

  // head byte held for the whole ack phase
  data_stable: assert property (@(posedge clk) disable iff (reset)
    (rd_ack && $past(rd_ack)) |-> $stable(rd_data))
    else $error("rd_data changed while rd_ack was high");

endmodule

// attached to every panel FIFO
bind panel_fifo decode_dga_chk chk_i (
  .clk     (clk),
  .reset   (reset),
  .rd_req  (pif.rd_req),
  .rd_ack  (pif.rd_ack),
  .full_n  (pif.full_n),
  .empty_n (pif.empty_n),
  .rd_data (pif.rd_data)
);

/* verif/tb_decode_dga.sv */
// ********************
// testbench for the panel and decode top level
// LFSR stimulus, FIFO queue model, status model and checks
// ********************

`timescale 1ns/1ps

module tb_decode_dga
  import dga_pkg::*;
();

  // cycle limit for every wait loop
  localparam int wait_lim = 40;

  logic       clk;
  logic       reset;
  logic [4:0] cmd;
  logic [7:0] idb_in;
  logic       power_sense;
  logic       rd_req;
  logic       rd_ack;
  logic [7:0] a;
  logic [3:0] idb_out;
  logic       epan_n;
  logic       full_n;
  logic       empty_n;
  logic       clear_n;
  logic       pow_fail_n;
  logic       stopped;

  // model of the FIFO contents and the status flags
  logic [7:0]  model_q[$];
  logic        m_fail;
  logic        m_stop;
  logic [15:0] lfsr;
  int          value_errs;
  int          fail_errs;

  decode_dga dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // one LFSR step per bit taken
  function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[6:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      value_errs++;
      $display("ERR %0t %s expected %b got %b", $time, name, exp, got);
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      value_errs++;
      $display("ERR %0t %s expected %0h got %0h", $time, name, exp, got);
    end
  endtask

  // command held for one cycle, then back to nop
  task automatic send(input cmd_e c, input logic [7:0] d);
    cmd    = c;
    idb_in = d;
    @(negedge clk);
    cmd    = cmd_nop;
  endtask

  task automatic idle(input int n);
    repeat (n) @(negedge clk);
  endtask

  // ********************
  // four-phase read, random hold time with ack high
  // ********************

  task automatic read_byte();
    int         t;
    int         hold;
    logic [7:0] exp;
    check_bit("rd_ack", rd_ack, 1'b0);
    check_byte("a", a, 8'h00);
    rd_req = 1'b1;
    t = 0;
    @(negedge clk);
    while (rd_ack !== 1'b1 && t < wait_lim) begin
      @(negedge clk);
      t++;
    end
    if (rd_ack !== 1'b1) begin
      fail_errs++;
      $display("timeout at %0t, rd_ack never rose", $time);
    end else if (model_q.size() == 0) begin
      fail_errs++;
      $display("rd_ack rose at %0t with nothing queued in the model", $time);
    end else begin
      exp  = model_q.pop_front();
      hold = int'(rand_bits(2));
      repeat (hold + 1) begin
        check_byte("a", a, exp);
        @(negedge clk);
      end
    end
    rd_req = 1'b0;
    t = 0;
    @(negedge clk);
    while (rd_ack !== 1'b0 && t < wait_lim) begin
      @(negedge clk);
      t++;
    end
    if (rd_ack !== 1'b0) begin
      fail_errs++;
      $display("timeout at %0t, rd_ack never fell", $time);
    end
    check_byte("a", a, 8'h00);
  endtask

  // status load, bus high nibble joins the status nibble
  task automatic status_load();
    logic [7:0] d;
    logic [3:0] nib;
    d   = rand_bits(8);
    nib = {1'b0, m_fail, 1'b0, m_stop};
    check_bit("epan_n", epan_n, 1'b1);
    send(cmd_ldstat, d);
    check_bit("epan_n", epan_n, 1'b0);
    check_byte("idb_out", {4'h0, idb_out}, {4'h0, nib});
    idle(1);
    check_bit("epan_n", epan_n, 1'b1);
    check_byte("idb_out", {4'h0, idb_out}, {4'h0, d[3:0]});
    model_q.push_back({d[7:4], nib});
  endtask

  // ********************
  // main sequence
  // ********************

  initial begin
    int         t;
    int         n;
    logic [7:0] d;
    reset       = 1'b1;
    cmd         = cmd_nop;
    idb_in      = 8'h00;
    power_sense = 1'b1;
    rd_req      = 1'b0;
    lfsr        = 16'd98;
    m_fail      = 1'b0;
    m_stop      = 1'b0;
    value_errs  = 0;
    fail_errs   = 0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    check_bit("full_n", full_n, 1'b1);
    check_bit("epan_n", epan_n, 1'b1);
    check_bit("pow_fail_n", pow_fail_n, 1'b1);
    check_bit("stopped", stopped, 1'b0);

    // clear after reset, panel loads dropped throughout
    for (int i = 0; i < clear_cycles; i++) begin
      check_bit("clear_n", clear_n, 1'b0);
      check_bit("empty_n", empty_n, 1'b0);
      cmd    = (i < clear_cycles - 1) ? cmd_ldpan : cmd_nop;
      idb_in = rand_bits(8);
      @(negedge clk);
    end
    check_bit("clear_n", clear_n, 1'b1);
    idle(2);
    check_bit("empty_n", empty_n, 1'b0);

    // random bursts come back in order
    for (int r = 0; r < 6; r++) begin
      n = int'(rand_bits(2)) + 1;
      for (int i = 0; i < n; i++) begin
        d = rand_bits(8);
        send(cmd_ldpan, d);
        model_q.push_back(d);
      end
      idle(int'(rand_bits(2)));
      for (int i = 0; i < n; i++) begin
        read_byte();
      end
    end

    // one byte past the depth is dropped
    for (int i = 0; i < fifo_depth + 1; i++) begin
      d = rand_bits(8);
      send(cmd_ldpan, d);
      if (i < fifo_depth) begin
        model_q.push_back(d);
      end
    end
    idle(2);
    check_bit("full_n", full_n, 1'b0);
    check_bit("empty_n", empty_n, 1'b1);
    for (int i = 0; i < fifo_depth; i++) begin
      read_byte();
    end
    check_bit("empty_n", empty_n, 1'b0);
    check_bit("full_n", full_n, 1'b1);

    // status loads, stop and start
    status_load();
    read_byte();
    send(cmd_stop, rand_bits(8));
    idle(1);
    m_stop = 1'b1;
    check_bit("stopped", stopped, 1'b1);
    status_load();
    read_byte();
    send(cmd_start, rand_bits(8));
    idle(1);
    m_stop = 1'b0;
    check_bit("stopped", stopped, 1'b0);

    // power loss, then return with a fresh clear
    for (int i = 0; i < 3; i++) begin
      send(cmd_ldpan, rand_bits(8));
    end
    power_sense = 1'b0;
    t = 0;
    while (pow_fail_n !== 1'b0 && t < wait_lim) begin
      @(negedge clk);
      t++;
    end
    if (pow_fail_n !== 1'b0) begin
      fail_errs++;
      $display("timeout at %0t, pow_fail_n never fell after power loss", $time);
    end
    m_fail = 1'b1;
    status_load();
    idle(2);
    check_bit("empty_n", empty_n, 1'b1);
    power_sense = 1'b1;
    t = 0;
    while (clear_n !== 1'b0 && t < wait_lim) begin
      @(negedge clk);
      t++;
    end
    if (clear_n !== 1'b0) begin
      fail_errs++;
      $display("timeout at %0t, no clear after power returned", $time);
    end
    n = 0;
    while (clear_n === 1'b0 && n < wait_lim) begin
      n++;
      @(negedge clk);
    end
    check_byte("clear_n low cycles", 8'(n), 8'(clear_cycles));
    model_q.delete();
    check_bit("empty_n", empty_n, 1'b0);
    check_bit("pow_fail_n", pow_fail_n, 1'b0);
    send(cmd_clrfail, rand_bits(8));
    idle(1);
    m_fail = 1'b0;
    check_bit("pow_fail_n", pow_fail_n, 1'b1);
    status_load();
    read_byte();

    idle(2);
    $display("value errors %0d, other failures %0d", value_errs, fail_errs);
    if (value_errs == 0 && fail_errs == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
